//--- compile.f
+incdir+include
source/ooo_pkg.sv
source/decode_unit.sv
source/map_table.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/dispatch_issue.sv
bench/dispatch_issue_tb.sv

//--- bench/dispatch_issue_tb.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module dispatch_issue_tb;

    localparam int prog_len     = 200;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = reset_cycles + 40 * prog_len;

    typedef struct packed {
        ooo_pkg::cdb_packet result;
        int unsigned        due;  // cycle the result may go on the cdb
    } pending_t;

    logic                   clock = 1'b0;
    logic                   reset = 1'b1;
    logic                   stall = 1'b0;
    ooo_pkg::if_id_packet   if_id_packet_in = '0;
    ooo_pkg::cdb_packet     cdb_packet_in = '0;
    ooo_pkg::rob2reg_packet rob_retire_packet;
    ooo_pkg::is_packet      is_packet_out;
    logic                   struc_hazard;
    logic                   squash;

    ooo_pkg::if_id_packet   program_mem [prog_len];
    ooo_pkg::rob2reg_packet expected_q [$];
    pending_t               exec_q [$];  // results in the execution model
    int                     expected_total;
    int                     retire_idx = 0;
    int                     error_count = 0;
    int                     check_count = 0;
    int                     cycle_count = 0;
    int unsigned            stim_cycle = 0;
    int                     fetch_pc = 0;
    int                     inflight = 0;
    int                     dispatched_total = 0;
    int                     withhold_left = 0;
    int                     stall_hold_left = 0;
    logic                   withhold_done = 1'b0;
    logic                   stall_hold_done = 1'b0;
    logic                   hazard_seen = 1'b0;
    logic                   exp_squash;

    dispatch_issue DUT (
        .clock             (clock),
        .reset             (reset),
        .stall             (stall),
        .if_id_packet_in   (if_id_packet_in),
        .cdb_packet_in     (cdb_packet_in),
        .rob_retire_packet (rob_retire_packet),
        .is_packet_out     (is_packet_out),
        .struc_hazard      (struc_hazard),
        .squash            (squash)
    );

    always #20 clock = ~clock;

    task automatic make_program();
        int kind;
        for (int pc = 0; pc < prog_len; pc++) begin
            kind = $urandom % 10;
            program_mem[pc]        = '0;
            program_mem[pc].valid  = 1'b1;
            program_mem[pc].pc     = 8'(pc);
            program_mem[pc].rd     = ooo_pkg::reg_idx_t'($urandom % `OOO_NUM_REGS);
            program_mem[pc].rs1    = ooo_pkg::reg_idx_t'($urandom % `OOO_NUM_REGS);
            program_mem[pc].rs2    = ooo_pkg::reg_idx_t'($urandom % `OOO_NUM_REGS);
            if (pc < `OOO_NUM_REGS || kind < 3) begin
                program_mem[pc].opcode = ooo_pkg::op_li;
                program_mem[pc].imm    = 16'($urandom);
                if (pc < `OOO_NUM_REGS) program_mem[pc].rd = ooo_pkg::reg_idx_t'(pc);
            end else if (kind == 9) begin
                program_mem[pc].opcode = ooo_pkg::op_beq;
                program_mem[pc].imm    = 16'(2 + $urandom % 5);  // short forward jump
                if ($urandom % 2) program_mem[pc].rs2 = program_mem[pc].rs1;  // always taken
            end else begin
                program_mem[pc].opcode = ooo_pkg::opcode_e'($urandom % 3);
            end
        end
    endtask

    // in-order model of the program, fills the expected retire stream
    function automatic int build_expected();
        ooo_pkg::word_t         regs [`OOO_NUM_REGS];
        ooo_pkg::if_id_packet   inst;
        ooo_pkg::rob2reg_packet exp;
        ooo_pkg::word_t         a;
        ooo_pkg::word_t         b;
        int                     pc;
        for (int i = 0; i < `OOO_NUM_REGS; i++) regs[i] = '0;
        pc = 0;
        expected_q.delete();
        while (pc < prog_len) begin
            inst      = program_mem[pc];
            a         = regs[inst.rs1];
            b         = regs[inst.rs2];
            exp       = '0;
            exp.valid = 1'b1;
            exp.rd    = inst.rd;
            exp.pc    = inst.pc;
            case (inst.opcode)
                ooo_pkg::op_add: exp.value = a + b;
                ooo_pkg::op_sub: exp.value = a - b;
                ooo_pkg::op_xor: exp.value = a ^ b;
                ooo_pkg::op_li:  exp.value = ooo_pkg::word_t'(inst.imm);
                default: begin
                    exp.is_branch = 1'b1;
                    exp.taken     = a == b;
                end
            endcase
            if (!exp.is_branch) regs[inst.rd] = exp.value;
            expected_q.push_back(exp);
            pc = exp.taken ? pc + int'(inst.imm) : pc + 1;
        end
        return expected_q.size();
    endfunction

    // execution unit, works only on the issued operand values
    function automatic ooo_pkg::cdb_packet execute(input ooo_pkg::is_packet inst);
        ooo_pkg::cdb_packet res;
        res       = '0;
        res.valid = 1'b1;
        res.tag   = inst.tag;
        case (inst.opcode)
            ooo_pkg::op_add: res.value = inst.rs1_value + inst.rs2_value;
            ooo_pkg::op_sub: res.value = inst.rs1_value - inst.rs2_value;
            ooo_pkg::op_xor: res.value = inst.rs1_value ^ inst.rs2_value;
            ooo_pkg::op_li:  res.value = ooo_pkg::word_t'(inst.imm);
            default:         res.taken = inst.rs1_value == inst.rs2_value;
        endcase
        return res;
    endfunction

    task automatic check_retire(input ooo_pkg::rob2reg_packet actual,
                                input ooo_pkg::rob2reg_packet expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: rob_retire_packet got %h expected %h", actual, expected);
        end
    endtask

    task automatic check_squash(input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: squash got %h expected %h", actual, expected);
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s got %h expected %h", name, actual, expected);
        end
    endtask

    // one rising edge of fetch, stall and execution
    task automatic drive_cycle();
        logic     accepted;
        pending_t pending;
        int       pick;
        accepted = if_id_packet_in.valid && !stall && !struc_hazard && !squash;
        stim_cycle++;
        if (!withhold_done && dispatched_total >= 40) begin
            withhold_done = 1'b1;
            withhold_left = 40;  // long enough to fill the rob
            hazard_seen   = 1'b0;
        end
        if (!stall_hold_done && dispatched_total >= 120) begin
            stall_hold_done = 1'b1;
            stall_hold_left = 60;
        end
        if (struc_hazard) hazard_seen = 1'b1;

        if (rob_retire_packet.valid) inflight--;
        if (squash) begin
            fetch_pc = int'(rob_retire_packet.pc) + int'(program_mem[rob_retire_packet.pc].imm);
            inflight = 0;
        end else if (accepted) begin
            fetch_pc++;
            inflight++;
            dispatched_total++;
        end
        if_id_packet_in <= (fetch_pc < prog_len) ? program_mem[fetch_pc] : '0;

        if (stall_hold_left > 0) begin
            stall_hold_left--;
            stall <= 1'b1;
            if (stall_hold_left == 0 && inflight != 0) begin
                error_count++;
                $display("stall held but %0d instructions in flight never retired", inflight);
            end
        end else begin
            stall <= ($urandom % 8) == 0;
        end

        if (squash) begin
            exec_q.delete();  // wrong path work
            cdb_packet_in <= '0;
        end else begin
            if (is_packet_out.valid) begin
                pending.result = execute(is_packet_out);
                pending.due    = stim_cycle + 1 + $urandom % 5;
                exec_q.push_back(pending);
            end
            pick = -1;
            for (int i = 0; i < exec_q.size(); i++) begin
                if (pick < 0 && withhold_left == 0 && exec_q[i].due <= stim_cycle) pick = i;
            end
            if (pick >= 0) begin
                cdb_packet_in <= exec_q[pick].result;
                exec_q.delete(pick);
            end else begin
                cdb_packet_in <= '0;
            end
        end

        if (withhold_left > 0) begin
            withhold_left--;
            if (withhold_left == 0 && !hazard_seen) begin
                error_count++;
                $display("struc_hazard never rose while cdb results were withheld");
            end
        end
    endtask

    // compare process, sampled away from the active edge
    always @(negedge clock) begin
        if (!reset) begin
            exp_squash = 1'b0;
            if (rob_retire_packet.valid) begin
                if (retire_idx < expected_total) begin
                    check_retire(rob_retire_packet, expected_q[retire_idx]);
                    exp_squash = expected_q[retire_idx].is_branch &&
                                 expected_q[retire_idx].taken;
                    retire_idx++;
                end else begin
                    error_count++;
                    $display("an instruction retired after the end of the program");
                end
            end
            check_squash(squash, exp_squash);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            error_count++;
            $display("the run hung with %0d of %0d instructions retired",
                     retire_idx, expected_total);
            $display("checks %0d errors %0d", check_count, error_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h83527538));
        make_program();
        expected_total = build_expected();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_level("is_packet_out.valid", is_packet_out.valid, 1'b0);
        check_level("rob_retire_packet.valid", rob_retire_packet.valid, 1'b0);
        check_level("squash", squash, 1'b0);
        check_level("struc_hazard", struc_hazard, 1'b0);
        while (retire_idx < expected_total) begin
            @(posedge clock);
            drive_cycle();
        end
        repeat (12) begin  // catch late or duplicate retires
            @(posedge clock);
            drive_cycle();
        end
        $display("checks %0d errors %0d retired %0d of %0d",
                 check_count, error_count, retire_idx, expected_total);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/dispatch_issue.sv
`timescale 1ns/1ps

module dispatch_issue (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,  // freezes dispatch only
    input  ooo_pkg::if_id_packet   if_id_packet_in,
    input  ooo_pkg::cdb_packet     cdb_packet_in,
    output ooo_pkg::rob2reg_packet rob_retire_packet,
    output ooo_pkg::is_packet      is_packet_out,
    output logic                   struc_hazard,
    output logic                   squash
);

    ooo_pkg::id_packet     decoded_packet;
    ooo_pkg::mt2rs_packet  mt2rs;
    ooo_pkg::rob2rs_packet rob2rs;
    ooo_pkg::rs2rob_packet rs2rob;
    ooo_pkg::rs2mt_packet  rs2mt;
    ooo_pkg::rob2mt_packet rob2mt;
    logic                  rob_full;
    logic                  rs_full;
    logic                  dispatch;

    assign struc_hazard = rob_full || rs_full;
    // one enable shared by map table, rob and rs
    assign dispatch = if_id_packet_in.valid && !stall && !struc_hazard && !squash;

    decode_unit decode_0 (
        .clock                (clock),
        .reset                (reset),
        .if_id_packet_in      (if_id_packet_in),
        .rob_retire_packet_in (rob_retire_packet),
        .id_packet_out        (decoded_packet)
    );

    map_table map_0 (
        .clock            (clock),
        .reset            (reset),
        .squash           (squash),
        .rs2mt_packet_in  (rs2mt),
        .cdb_packet_in    (cdb_packet_in),
        .rob2mt_packet_in (rob2mt),
        .id_packet_in     (decoded_packet),
        .mt2rs_packet_out (mt2rs)
    );

    reorder_buffer rob_0 (
        .clock              (clock),
        .reset              (reset),
        .dispatch           (dispatch),
        .id_packet_in       (decoded_packet),
        .rs2rob_packet_in   (rs2rob),
        .cdb_packet_in      (cdb_packet_in),
        .rob2rs_packet_out  (rob2rs),
        .rob2mt_packet_out  (rob2mt),
        .rob2reg_packet_out (rob_retire_packet),
        .full               (rob_full),
        .squash             (squash)
    );

    reservation_station rs_0 (
        .clock             (clock),
        .reset             (reset),
        .squash            (squash),
        .dispatch          (dispatch),
        .id_packet_in      (decoded_packet),
        .mt2rs_packet_in   (mt2rs),
        .rob2rs_packet_in  (rob2rs),
        .cdb_packet_in     (cdb_packet_in),
        .rs2rob_packet_out (rs2rob),
        .rs2mt_packet_out  (rs2mt),
        .is_packet_out     (is_packet_out),
        .full              (rs_full)
    );

endmodule

//--- source/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reservation_station (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  squash,
    input  logic                  dispatch,
    input  ooo_pkg::id_packet     id_packet_in,
    input  ooo_pkg::mt2rs_packet  mt2rs_packet_in,
    input  ooo_pkg::rob2rs_packet rob2rs_packet_in,
    input  ooo_pkg::cdb_packet    cdb_packet_in,
    output ooo_pkg::rs2rob_packet rs2rob_packet_out,
    output ooo_pkg::rs2mt_packet  rs2mt_packet_out,
    output ooo_pkg::is_packet     is_packet_out,
    output logic                  full
);

    localparam int slot_bits = $clog2(`OOO_RS_DEPTH);

    typedef struct packed {
        logic           ready;
        ooo_pkg::tag_t  tag;
        ooo_pkg::word_t value;
    } operand_t;

    typedef struct packed {
        ooo_pkg::opcode_e opcode;
        ooo_pkg::tag_t    tag;
        logic [15:0]      imm;
        logic [7:0]       pc;
        operand_t         src1;
        operand_t         src2;
    } rs_entry_t;

    rs_entry_t                entries [`OOO_RS_DEPTH];
    logic [`OOO_RS_DEPTH-1:0] busy;
    logic [slot_bits-1:0]     age [`OOO_RS_DEPTH];  // 0 is youngest
    logic [`OOO_RS_DEPTH-1:0] can_issue;
    logic                     issue;
    logic [slot_bits-1:0]     issue_slot;
    logic [slot_bits-1:0]     free_slot;
    logic                     uses_regs;
    operand_t                 new_src1;
    operand_t                 new_src2;

    // operand at dispatch: regfile, then completed rob entry, then cdb
    function automatic operand_t resolve(input logic used, input logic renamed,
                                         input ooo_pkg::tag_t tag,
                                         input ooo_pkg::word_t rf_value,
                                         input logic rob_ready,
                                         input ooo_pkg::word_t rob_value,
                                         input ooo_pkg::cdb_packet cdb);
        operand_t op;
        op.tag   = tag;
        op.ready = 1'b1;
        if (!used || !renamed) begin
            op.value = rf_value;
        end else if (rob_ready) begin
            op.value = rob_value;
        end else if (cdb.valid && cdb.tag == tag) begin
            op.value = cdb.value;
        end else begin
            op.ready = 1'b0;  // wait for the broadcast
            op.value = '0;
        end
        return op;
    endfunction

    function automatic operand_t capture(input operand_t op, input ooo_pkg::cdb_packet cdb);
        operand_t res;
        res = op;
        if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

    assign uses_regs = id_packet_in.opcode != ooo_pkg::op_li;
    assign new_src1  = resolve(uses_regs, mt2rs_packet_in.rs1_renamed, mt2rs_packet_in.rs1_tag,
                               id_packet_in.rs1_value, rob2rs_packet_in.rs1_ready,
                               rob2rs_packet_in.rs1_value, cdb_packet_in);
    assign new_src2  = resolve(uses_regs, mt2rs_packet_in.rs2_renamed, mt2rs_packet_in.rs2_tag,
                               id_packet_in.rs2_value, rob2rs_packet_in.rs2_ready,
                               rob2rs_packet_in.rs2_value, cdb_packet_in);
    assign full      = &busy;

    always_comb begin
        rs2rob_packet_out.rs1_tag = mt2rs_packet_in.rs1_tag;
        rs2rob_packet_out.rs2_tag = mt2rs_packet_in.rs2_tag;
        rs2mt_packet_out.valid    = dispatch && id_packet_in.opcode != ooo_pkg::op_beq;
        rs2mt_packet_out.rd       = id_packet_in.rd;
        rs2mt_packet_out.tag      = rob2rs_packet_in.new_tag;
    end

    // oldest ready entry, only stored ready bits count
    always_comb begin
        issue      = 1'b0;
        issue_slot = '0;
        free_slot  = '0;
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            can_issue[i] = busy[i] && entries[i].src1.ready && entries[i].src2.ready;
            if (can_issue[i] && (!issue || age[i] > age[issue_slot])) begin
                issue      = 1'b1;
                issue_slot = slot_bits'(i);
            end
        end
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = slot_bits'(i);  // lowest free slot
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            // ages stay unique and dense
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                age[i] <= age[i] + slot_bits'(dispatch)
                          - slot_bits'(issue && age[i] > age[issue_slot]);
            end
            if (issue) begin
                busy[issue_slot] <= 1'b0;
            end
            if (dispatch) begin
                busy[free_slot] <= 1'b1;
                age[free_slot]  <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            entries[i].src1 <= capture(entries[i].src1, cdb_packet_in);
            entries[i].src2 <= capture(entries[i].src2, cdb_packet_in);
        end
        if (dispatch) begin
            entries[free_slot] <= '{opcode: id_packet_in.opcode,
                                    tag:    rob2rs_packet_in.new_tag,
                                    imm:    id_packet_in.imm,
                                    pc:     id_packet_in.pc,
                                    src1:   new_src1,
                                    src2:   new_src2};
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            is_packet_out <= '0;
        end else begin
            is_packet_out.valid     <= issue;
            is_packet_out.opcode    <= entries[issue_slot].opcode;
            is_packet_out.tag       <= entries[issue_slot].tag;
            is_packet_out.rs1_value <= entries[issue_slot].src1.value;
            is_packet_out.rs2_value <= entries[issue_slot].src2.value;
            is_packet_out.imm       <= entries[issue_slot].imm;
            is_packet_out.pc        <= entries[issue_slot].pc;
        end
    end

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch,
    input  ooo_pkg::id_packet      id_packet_in,
    input  ooo_pkg::rs2rob_packet  rs2rob_packet_in,
    input  ooo_pkg::cdb_packet     cdb_packet_in,
    output ooo_pkg::rob2rs_packet  rob2rs_packet_out,
    output ooo_pkg::rob2mt_packet  rob2mt_packet_out,
    output ooo_pkg::rob2reg_packet rob2reg_packet_out,
    output logic                   full,
    output logic                   squash
);

    localparam int count_bits = $clog2(`OOO_ROB_DEPTH + 1);

    typedef struct packed {
        ooo_pkg::reg_idx_t rd;
        ooo_pkg::opcode_e  opcode;
        logic [7:0]        pc;
        ooo_pkg::word_t    value;
        logic              taken;
    } rob_entry_t;

    rob_entry_t                entries [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] complete;
    ooo_pkg::tag_t             head;
    ooo_pkg::tag_t             tail;
    logic [count_bits-1:0]     count;

    logic                      head_cdb;  // head finishes on the cdb this cycle
    logic                      head_is_beq;
    logic                      retire;
    ooo_pkg::word_t            head_value;
    logic                      head_taken;

    assign head_cdb    = cdb_packet_in.valid && cdb_packet_in.tag == head;
    assign head_is_beq = entries[head].opcode == ooo_pkg::op_beq;
    assign retire      = !squash && count != '0 && (complete[head] || head_cdb);
    assign head_value  = head_cdb ? cdb_packet_in.value : entries[head].value;
    assign head_taken  = head_cdb ? cdb_packet_in.taken : entries[head].taken;
    assign full        = count == count_bits'(`OOO_ROB_DEPTH);

    always_comb begin
        rob2rs_packet_out.new_tag   = tail;
        rob2rs_packet_out.rs1_ready = complete[rs2rob_packet_in.rs1_tag];
        rob2rs_packet_out.rs1_value = entries[rs2rob_packet_in.rs1_tag].value;
        rob2rs_packet_out.rs2_ready = complete[rs2rob_packet_in.rs2_tag];
        rob2rs_packet_out.rs2_value = entries[rs2rob_packet_in.rs2_tag].value;

        // map entry freed in the same cycle the head leaves
        rob2mt_packet_out.valid = retire;
        rob2mt_packet_out.rd    = entries[head].rd;
        rob2mt_packet_out.tag   = head;
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            complete <= '0;
        end else begin
            if (dispatch) begin
                tail <= tail + 1'b1;
            end
            if (cdb_packet_in.valid) begin
                complete[cdb_packet_in.tag] <= 1'b1;
            end
            if (retire) begin
                complete[head] <= 1'b0;  // entry is free for reuse
                head           <= head + 1'b1;
            end
            count <= count + count_bits'(dispatch) - count_bits'(retire);
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            entries[tail].rd     <= id_packet_in.rd;
            entries[tail].opcode <= id_packet_in.opcode;
            entries[tail].pc     <= id_packet_in.pc;
        end
        if (cdb_packet_in.valid) begin
            entries[cdb_packet_in.tag].value <= cdb_packet_in.value;
            entries[cdb_packet_in.tag].taken <= cdb_packet_in.taken;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rob2reg_packet_out <= '0;
            squash             <= 1'b0;
        end else begin
            rob2reg_packet_out.valid     <= retire;
            rob2reg_packet_out.rd        <= entries[head].rd;
            rob2reg_packet_out.value     <= head_value;
            rob2reg_packet_out.is_branch <= head_is_beq;
            rob2reg_packet_out.taken     <= head_is_beq && head_taken;
            rob2reg_packet_out.pc        <= entries[head].pc;
            squash                       <= retire && head_is_beq && head_taken;  // mispredict
        end
    end

endmodule

//--- source/map_table.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  squash,
    input  ooo_pkg::rs2mt_packet  rs2mt_packet_in,
    input  ooo_pkg::cdb_packet    cdb_packet_in,
    input  ooo_pkg::rob2mt_packet rob2mt_packet_in,
    input  ooo_pkg::id_packet     id_packet_in,
    output ooo_pkg::mt2rs_packet  mt2rs_packet_out
);

    ooo_pkg::tag_t            map_tag [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] renamed;  // value lives in the rob
    logic [`OOO_NUM_REGS-1:0] ready;    // producer has broadcast
    logic [`OOO_NUM_REGS-1:0] cdb_hit;

    always_comb begin
        for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            cdb_hit[i] = cdb_packet_in.valid && renamed[i] && map_tag[i] == cdb_packet_in.tag;
        end
        mt2rs_packet_out.rs1_renamed = renamed[id_packet_in.rs1];
        mt2rs_packet_out.rs1_tag     = map_tag[id_packet_in.rs1];
        mt2rs_packet_out.rs2_renamed = renamed[id_packet_in.rs2];
        mt2rs_packet_out.rs2_tag     = map_tag[id_packet_in.rs2];
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            renamed <= '0;
            ready   <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                map_tag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                if (cdb_hit[i]) begin
                    ready[i] <= 1'b1;
                end
                // only a finished producer retires, and only if no younger writer took rd
                if (rob2mt_packet_in.valid && renamed[i] && (ready[i] || cdb_hit[i]) &&
                    rob2mt_packet_in.rd == ooo_pkg::reg_idx_t'(i) &&
                    map_tag[i] == rob2mt_packet_in.tag) begin
                    renamed[i] <= 1'b0;
                    ready[i]   <= 1'b0;
                end
            end
            if (rs2mt_packet_in.valid) begin  // new writer wins over retire
                renamed[rs2mt_packet_in.rd] <= 1'b1;
                ready[rs2mt_packet_in.rd]   <= 1'b0;
                map_tag[rs2mt_packet_in.rd] <= rs2mt_packet_in.tag;
            end
        end
    end

endmodule

//--- source/decode_unit.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module decode_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  ooo_pkg::if_id_packet   if_id_packet_in,
    input  ooo_pkg::rob2reg_packet rob_retire_packet_in,
    output ooo_pkg::id_packet      id_packet_out
);

    ooo_pkg::word_t regs [`OOO_NUM_REGS];  // architectural state
    logic           rf_write;

    // branches retire without a destination
    assign rf_write = rob_retire_packet_in.valid && !rob_retire_packet_in.is_branch;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write) begin
            regs[rob_retire_packet_in.rd] <= rob_retire_packet_in.value;
        end
    end

    function automatic ooo_pkg::word_t read_reg(input ooo_pkg::reg_idx_t idx);
        if (rf_write && rob_retire_packet_in.rd == idx) begin
            return rob_retire_packet_in.value;  // same-cycle retire bypass
        end
        return regs[idx];
    endfunction

    always_comb begin
        id_packet_out.valid     = if_id_packet_in.valid;
        id_packet_out.opcode    = if_id_packet_in.opcode;
        id_packet_out.rd        = if_id_packet_in.rd;
        id_packet_out.rs1       = if_id_packet_in.rs1;
        id_packet_out.rs2       = if_id_packet_in.rs2;
        id_packet_out.imm       = if_id_packet_in.imm;
        id_packet_out.pc        = if_id_packet_in.pc;
        id_packet_out.rs1_value = read_reg(if_id_packet_in.rs1);
        if (if_id_packet_in.opcode == ooo_pkg::op_li) begin
            id_packet_out.rs2_value = ooo_pkg::word_t'(if_id_packet_in.imm);  // zero extend
        end else begin
            id_packet_out.rs2_value = read_reg(if_id_packet_in.rs2);
        end
    end

endmodule

//--- source/ooo_pkg.sv
`include "ooo_settings.svh"

package ooo_pkg;

    localparam int tag_bits = $clog2(`OOO_ROB_DEPTH);
    localparam int reg_bits = $clog2(`OOO_NUM_REGS);

    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [tag_bits-1:0]  tag_t;   // rob entry index
    typedef logic [reg_bits-1:0]  reg_idx_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_li,   // rd = imm
        op_beq   // predicted not taken
    } opcode_e;

    typedef struct packed {
        logic        valid;
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] imm;
        logic [7:0]  pc;
    } if_id_packet;

    typedef struct packed {
        logic        valid;
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] imm;
        logic [7:0]  pc;
        word_t       rs1_value;
        word_t       rs2_value;  // imm for li
    } id_packet;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
        logic  taken;  // branch outcome
    } cdb_packet;

    // tag only meaningful when renamed
    typedef struct packed {
        logic rs1_renamed;
        tag_t rs1_tag;
        logic rs2_renamed;
        tag_t rs2_tag;
    } mt2rs_packet;

    typedef struct packed {
        tag_t  new_tag;
        logic  rs1_ready;
        word_t rs1_value;
        logic  rs2_ready;
        word_t rs2_value;
    } rob2rs_packet;

    typedef struct packed {
        tag_t rs1_tag;
        tag_t rs2_tag;
    } rs2rob_packet;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        tag_t     tag;
    } rs2mt_packet;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        tag_t     tag;
    } rob2mt_packet;

    typedef struct packed {
        logic        valid;
        opcode_e     opcode;
        tag_t        tag;
        word_t       rs1_value;
        word_t       rs2_value;
        logic [15:0] imm;
        logic [7:0]  pc;
    } is_packet;

    typedef struct packed {
        logic       valid;
        reg_idx_t   rd;
        word_t      value;
        logic       is_branch;
        logic       taken;
        logic [7:0] pc;
    } rob2reg_packet;

endpackage

//--- include/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

`define OOO_XLEN      32  // data width
`define OOO_NUM_REGS  8   // architectural registers

// power of two, tags wrap naturally
`define OOO_ROB_DEPTH 8
`define OOO_RS_DEPTH  4

`endif
